/* filelist.f */
+incdir+common
common/icache_pkg.sv
icache/icache_tag_array.sv
icache/icache_data_ram.sv
icache/icache.sv
hw/inst_mem.sv
hw/icache_top.sv
testbench/icache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the instruction cache testbench with Verilator and runs it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary --timing -sv -f filelist.f --top-module icache_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vicache_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished"
exit 0

/* testbench/icache_tb.sv */
`include "icache_settings.svh"

module icache_tb;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 4;
    localparam int OFF_W         = `ICACHE_OFFSET_BITS;
    localparam int IDX_W         = `ICACHE_INDEX_BITS;
    localparam int LINE_W        = `IMEM_LINE_BITS;
    localparam int LINES         = 2 ** LINE_W;
    localparam int COLD_LINES    = 8;
    localparam int STREAM_LEN    = 16;
    localparam int STRESS_LEN    = 400;
    localparam int TOTAL_FETCHES = 2 * COLD_LINES + STREAM_LEN + STRESS_LEN + 3;
    localparam int WATCHDOG_TIME = CLK_PERIOD * 20 * TOTAL_FETCHES
                                   + CLK_PERIOD * (LINES + 4 * RESET_CYCLES);

    // latency code meaning either a hit or a miss is fine
    localparam int HIT_OR_MISS = 0;

    logic                clk;
    logic                rst;
    logic                valid;
    icache_pkg::index_t  index;
    icache_pkg::tag_t    tag;
    icache_pkg::offset_t offset;
    logic                addr_ok;
    logic                data_ok;
    icache_pkg::word_t   rdata;
    logic                load_en;
    logic [LINE_W-1:0]   load_line;
    icache_pkg::line_t   load_data;

    // memory image as the testbench loaded it
    icache_pkg::line_t shadow [LINES];

    // outstanding fetches, oldest first
    icache_pkg::addr_t pend_addr [$];
    int                pend_cyc [$];
    int                pend_lat [$];

    int exp_lat;

    icache_top icache_top_inst (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .load_en   (load_en),
        .load_line (load_line),
        .load_data (load_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // expected word: line from bits 10:3, upper word when bit 2 is set
    function automatic icache_pkg::word_t expected_word(input icache_pkg::addr_t a);
        icache_pkg::line_t line;
        line = shadow[a[LINE_W+OFF_W-1:OFF_W]];
        if (a[OFF_W-1]) begin
            return line[63:32];
        end
        return line[31:0];
    endfunction

    task automatic check_word(input icache_pkg::word_t got, input icache_pkg::word_t expected,
                              input icache_pkg::addr_t a);
        if (got !== expected) begin
            $display("FAILED at time %0t: word for address %h is %h, expected %h",
                     $time, a, got, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_latency(input int cycles, input int expected, input string what);
        logic ok;
        if (expected == HIT_OR_MISS) begin
            ok = (cycles == 1) || (cycles == 3);
        end else begin
            ok = (cycles == expected);
        end
        if (!ok) begin
            $display("FAILED at time %0t: %s took %0d cycles, expected %0d",
                     $time, what, cycles, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "latency mismatch");
        end
    endtask

    task automatic reset_dut();
        rst   <= 1'b1;
        valid <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic load_memory();
        icache_pkg::line_t data;
        for (int i = 0; i < LINES; i++) begin
            data      = {$urandom, $urandom};
            shadow[i] = data;
            load_en   <= 1'b1;
            load_line <= i[LINE_W-1:0];
            load_data <= data;
            @(posedge clk);
        end
        load_en <= 1'b0;
    endtask

    // holds the request until the cache takes it
    task automatic fetch(input icache_pkg::addr_t a, input int lat);
        exp_lat = lat;
        valid  <= 1'b1;
        tag    <= a[31:IDX_W+OFF_W];
        index  <= a[IDX_W+OFF_W-1:OFF_W];
        offset <= a[OFF_W-1:0];
        do begin
            @(negedge clk);
        end while (!addr_ok);
        @(posedge clk);
    endtask

    task automatic drain();
        valid <= 1'b0;
        while (pend_addr.size() != 0) begin
            @(posedge clk);
        end
    endtask

    // checker, samples at the falling edge where everything is settled
    initial begin
        icache_pkg::addr_t a;
        int cyc;
        int acc_cyc;
        int lat;
        cyc = 0;
        forever begin
            @(negedge clk);
            cyc++;
            if (data_ok === 1'b1) begin
                if (pend_addr.size() == 0) begin
                    $display("data_ok came without an outstanding fetch at time %0t", $time);
                    $display("TESTBENCH FAILED");
                    $fatal(1, "unexpected response");
                end
                a       = pend_addr.pop_front();
                acc_cyc = pend_cyc.pop_front();
                lat     = pend_lat.pop_front();
                check_word(rdata, expected_word(a), a);
                check_latency(cyc - acc_cyc, lat, "fetch");
            end
            if (valid && addr_ok) begin
                pend_addr.push_back({tag, index, offset});
                pend_cyc.push_back(cyc);
                pend_lat.push_back(exp_lat);
            end
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("fetch response missing, run stopped at time %0t", $time);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        icache_pkg::addr_t a;
        logic [31:0] r;
        time t0;
        int unsigned seed_val;
        seed_val  = $urandom(2036);
        exp_lat   = HIT_OR_MISS;
        rst       <= 1'b1;
        valid     <= 1'b0;
        index     <= '0;
        tag       <= '0;
        offset    <= '0;
        load_en   <= 1'b0;
        load_line <= '0;
        load_data <= '0;
        reset_dut();
        load_memory();

        // cold miss, then the other word of the same line hits
        for (int i = 0; i < COLD_LINES; i++) begin
            a = (icache_pkg::addr_t'(i) << OFF_W) | ((i % 2) << 2);
            fetch(a, 3);
            fetch(a ^ 32'h4, 1);
        end
        drain();

        // streaming over resident lines, one word per cycle
        t0 = $time;
        for (int k = 0; k < STREAM_LEN; k++) begin
            a = (icache_pkg::addr_t'((k / 2) % COLD_LINES) << OFF_W) | ((k % 2) << 2);
            fetch(a, 1);
        end
        check_latency(int'(($time - t0) / CLK_PERIOD), STREAM_LEN, "stream");
        drain();

        // tags 0..7, the upper four alias in the backing memory
        for (int n = 0; n < STRESS_LEN; n++) begin
            r = $urandom;
            a = r & 32'h0000_0FFC;
            fetch(a, HIT_OR_MISS);
        end
        drain();

        // make a line resident, reset, it must miss again
        a = 32'h0000_0104;
        fetch(a, HIT_OR_MISS);
        fetch(a ^ 32'h4, 1);
        drain();
        @(posedge clk);
        reset_dut();
        fetch(a, 3);
        drain();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* hw/icache_top.sv */
`include "icache_settings.svh"

module icache_top (
    input  logic                       clk,
    input  logic                       rst,
    // fetch port
    input  logic                       valid,
    input  icache_pkg::index_t         index,
    input  icache_pkg::tag_t           tag,
    input  icache_pkg::offset_t        offset,
    output logic                       addr_ok,
    output logic                       data_ok,
    output icache_pkg::word_t          rdata,
    // memory load port
    input  logic                       load_en,
    input  logic [`IMEM_LINE_BITS-1:0] load_line,
    input  icache_pkg::line_t          load_data
);

    icache_pkg::addr_t rd_addr;
    icache_pkg::line_t ret_data;

    icache icache_inst (
        .clk      (clk),
        .rst      (rst),
        .valid    (valid),
        .index    (index),
        .tag      (tag),
        .offset   (offset),
        .addr_ok  (addr_ok),
        .data_ok  (data_ok),
        .rdata    (rdata),
        // memory answers in the same cycle, no request strobe needed
        .rd_req   (),
        .rd_addr  (rd_addr),
        .ret_data (ret_data)
    );

    inst_mem inst_mem_inst (
        .clk       (clk),
        .load_en   (load_en),
        .load_line (load_line),
        .load_data (load_data),
        .rd_addr   (rd_addr),
        .ret_data  (ret_data)
    );

endmodule

/* hw/inst_mem.sv */
`include "icache_settings.svh"

module inst_mem (
    input  logic                       clk,
    input  logic                       load_en,
    input  logic [`IMEM_LINE_BITS-1:0] load_line,
    input  icache_pkg::line_t          load_data,
    input  icache_pkg::addr_t          rd_addr,
    output icache_pkg::line_t          ret_data
);

    localparam int LINES = 2 ** `IMEM_LINE_BITS;

    icache_pkg::line_t mem [LINES];

    logic [`IMEM_LINE_BITS-1:0] rd_line;

    // filled before fetching starts
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_line] <= load_data;
        end
    end

    // line number sits just above the byte offset, upper bits alias
    assign rd_line  = rd_addr[`IMEM_LINE_BITS+`ICACHE_OFFSET_BITS-1:`ICACHE_OFFSET_BITS];
    assign ret_data = mem[rd_line];

endmodule

/* icache/icache.sv */
`include "icache_settings.svh"

module icache (
    input  logic                clk,
    input  logic                rst,
    // fetch side
    input  logic                valid,
    input  icache_pkg::index_t  index,
    input  icache_pkg::tag_t    tag,
    input  icache_pkg::offset_t offset,
    output logic                addr_ok,
    output logic                data_ok,
    output icache_pkg::word_t   rdata,
    // memory side
    output logic                rd_req,
    output icache_pkg::addr_t   rd_addr,
    input  icache_pkg::line_t   ret_data
);

    icache_pkg::cache_state_t state;
    icache_pkg::cache_state_t next_state;

    // request buffer
    icache_pkg::index_t  req_index;
    icache_pkg::tag_t    req_tag;
    icache_pkg::offset_t req_offset;

    logic accept;
    logic victim_way;
    icache_pkg::line_t miss_line;

    // tag lookup
    icache_pkg::vtag_t way0_vtag;
    icache_pkg::vtag_t way1_vtag;
    logic way0_hit;
    logic way1_hit;
    logic cache_hit;
    logic we_way0;
    logic we_way1;

    // data ram interface
    logic               ram_cen;
    logic               ram_wen;
    logic [127:0]       ram_bwen;
    logic [127:0]       ram_wdata;
    logic [127:0]       ram_q;
    icache_pkg::index_t ram_addr;

    icache_pkg::line_t way0_line;
    icache_pkg::line_t way1_line;
    logic              word_sel;
    icache_pkg::word_t hit_word;
    icache_pkg::word_t refill_word;

    // upper or lower word of a line
    function automatic icache_pkg::word_t pick_word(input icache_pkg::line_t line,
                                                    input logic upper);
        icache_pkg::word_t w;
        w = upper ? line[63:32] : line[31:0];
        return w;
    endfunction

    assign accept = valid && addr_ok;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_index  <= index;
            req_tag    <= tag;
            req_offset <= offset;
        end
    end

    // free-running toggle, its REFILL value picks the victim
    always_ff @(posedge clk) begin
        if (rst) begin
            victim_way <= 1'b0;
        end else begin
            victim_way <= ~victim_way;
        end
    end

    // miss buffer, loaded at the end of MISS
    always_ff @(posedge clk) begin
        if (state == icache_pkg::MISS) begin
            miss_line <= ret_data;
        end
    end

    icache_tag_array tag_array_inst (
        .clk       (clk),
        .rst       (rst),
        .rd_index  (req_index),
        .way0_vtag (way0_vtag),
        .way1_vtag (way1_vtag),
        .we_way0   (we_way0),
        .we_way1   (we_way1),
        .wr_tag    (req_tag)
    );

    assign way0_hit = way0_vtag[`ICACHE_TAG_BITS]
                      && (way0_vtag[`ICACHE_TAG_BITS-1:0] == req_tag);
    assign way1_hit = way1_vtag[`ICACHE_TAG_BITS]
                      && (way1_vtag[`ICACHE_TAG_BITS-1:0] == req_tag);
    assign cache_hit = way0_hit || way1_hit;

    assign we_way0 = (state == icache_pkg::REFILL) && !victim_way;
    assign we_way1 = (state == icache_pkg::REFILL) && victim_way;

    // read on acceptance, write the victim half in REFILL
    assign ram_cen  = !(accept || (state == icache_pkg::REFILL));
    assign ram_wen  = !(state == icache_pkg::REFILL);
    assign ram_addr = (state == icache_pkg::REFILL) ? req_index : index;
    assign ram_wdata = {miss_line, miss_line};
    assign ram_bwen = victim_way ? {{64{1'b0}}, {64{1'b1}}} : {{64{1'b1}}, {64{1'b0}}};

    icache_data_ram data_ram_inst (
        .clk   (clk),
        .cen   (ram_cen),
        .wen   (ram_wen),
        .bwen  (ram_bwen),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .q     (ram_q)
    );

    // way 0 low half, way 1 high half
    assign way0_line = ram_q[63:0];
    assign way1_line = ram_q[127:64];

    assign word_sel    = req_offset[`ICACHE_OFFSET_BITS-1];
    assign hit_word    = way0_hit ? pick_word(way0_line, word_sel)
                                  : pick_word(way1_line, word_sel);
    assign refill_word = pick_word(miss_line, word_sel);

    assign rdata   = (state == icache_pkg::REFILL) ? refill_word : hit_word;
    assign data_ok = ((state == icache_pkg::LOOKUP) && cache_hit)
                     || (state == icache_pkg::REFILL);
    assign addr_ok = (state == icache_pkg::IDLE)
                     || ((state == icache_pkg::LOOKUP) && cache_hit);

    // line-aligned fetch address
    assign rd_req  = (state == icache_pkg::MISS);
    assign rd_addr = {req_tag, req_index, {`ICACHE_OFFSET_BITS{1'b0}}};

    always_comb begin
        next_state = state;
        case (state)
            icache_pkg::IDLE: begin
                if (valid) begin
                    next_state = icache_pkg::LOOKUP;
                end
            end
            icache_pkg::LOOKUP: begin
                if (!cache_hit) begin
                    next_state = icache_pkg::MISS;
                end else if (!valid) begin
                    next_state = icache_pkg::IDLE;
                end
            end
            icache_pkg::MISS: begin
                next_state = icache_pkg::REFILL;
            end
            icache_pkg::REFILL: begin
                next_state = icache_pkg::IDLE;
            end
            default: begin
                next_state = icache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= icache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

endmodule

/* icache/icache_data_ram.sv */
`include "icache_settings.svh"

module icache_data_ram (
    input  logic               clk,
    input  logic               cen,
    input  logic               wen,
    input  logic [127:0]       bwen,
    input  icache_pkg::index_t addr,
    input  logic [127:0]       wdata,
    output logic [127:0]       q
);

    localparam int DEPTH = 2 ** `ICACHE_INDEX_BITS;

    // way 0 in bits 63:0, way 1 in bits 127:64
    logic [127:0] mem [DEPTH];

    // cen, wen and bwen are active low like the macro
    always_ff @(posedge clk) begin
        if (!cen) begin
            if (!wen) begin
                mem[addr] <= (mem[addr] & bwen) | (wdata & ~bwen);
            end else begin
                q <= mem[addr];
            end
        end
    end

endmodule

/* icache/icache_tag_array.sv */
`include "icache_settings.svh"

module icache_tag_array (
    input  logic               clk,
    input  logic               rst,
    input  icache_pkg::index_t rd_index,
    output icache_pkg::vtag_t  way0_vtag,
    output icache_pkg::vtag_t  way1_vtag,
    input  logic               we_way0,
    input  logic               we_way1,
    input  icache_pkg::tag_t   wr_tag
);

    localparam int SETS = 2 ** `ICACHE_INDEX_BITS;

    // one table per way
    icache_pkg::vtag_t vtag_tab [2][SETS];

    logic [1:0] we;

    assign we = {we_way1, we_way0};

    // refill writes the set that was looked up
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < SETS; s++) begin
                    vtag_tab[w][s][`ICACHE_TAG_BITS] <= 1'b0;
                end
            end
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (we[w]) begin
                    vtag_tab[w][rd_index] <= {1'b1, wr_tag};
                end
            end
        end
    end

    // asynchronous read
    assign way0_vtag = vtag_tab[0][rd_index];
    assign way1_vtag = vtag_tab[1][rd_index];

endmodule

/* common/icache_pkg.sv */
`include "icache_settings.svh"

package icache_pkg;

    // address fields
    typedef logic [`ICACHE_TAG_BITS-1:0]    tag_t;
    typedef logic [`ICACHE_INDEX_BITS-1:0]  index_t;
    typedef logic [`ICACHE_OFFSET_BITS-1:0] offset_t;

    // full byte address, tag above index above offset
    typedef logic [`ICACHE_TAG_BITS+`ICACHE_INDEX_BITS+`ICACHE_OFFSET_BITS-1:0] addr_t;

    // one instruction word
    typedef logic [31:0] word_t;

    // one cache line, two words
    typedef logic [63:0] line_t;

    // valid bit sits above the tag
    typedef logic [`ICACHE_TAG_BITS:0] vtag_t;

    // controller states
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL
    } cache_state_t;

endpackage

/* common/icache_settings.svh */
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// address split: tag | index | byte offset
`define ICACHE_TAG_BITS     23

// 64 sets
`define ICACHE_INDEX_BITS   6

// 8 bytes per line, two instruction words
`define ICACHE_OFFSET_BITS  3

// backing memory depth in lines, 256 lines
`define IMEM_LINE_BITS      8

`endif
